// File: Bender.yml
package:
  name: rs

sources:
  - files:
      - src/ooo_pkg.sv
      - src/rs_select_if.sv
      - src/psel_gen.sv
      - src/rs_issue_select.sv
      - src/rs.sv
      - src/rs_top.sv
  - target: test
    files:
      - verif/rs_checker.sv
      - verif/rs_monitor.sv
      - verif/rs_tb.sv

// File: sim.f
src/ooo_pkg.sv
src/rs_select_if.sv
src/psel_gen.sv
src/rs_issue_select.sv
src/rs.sv
src/rs_top.sv
verif/rs_checker.sv
verif/rs_monitor.sv
verif/rs_tb.sv

// File: src/ooo_pkg.sv
package ooo_pkg;

    // machine widths
    localparam int n_way    = 2;
    localparam int rs_depth = 8;

    // functional units per class
    localparam int num_alu  = 2;
    localparam int num_mult = 1;
    localparam int num_ld   = 1;
    localparam int num_st   = 1;
    localparam int num_br   = 1;

    typedef logic [5:0] preg_t;

    // one-hot per in-flight branch
    typedef logic [3:0] br_mask_t;

    typedef enum logic [2:0] {
        fu_alu,
        fu_mult,
        fu_ld,
        fu_st,
        fu_br
    } fu_type_e;

    typedef enum logic [1:0] {
        no_task,
        squash,
        clear
    } br_task_e;

    typedef struct packed {
        preg_t tag;
        logic  ready;
    } src_tag_t;

    // as delivered by rename
    typedef struct packed {
        logic       valid;
        fu_type_e   fu_type;
        logic [7:0] op;
        preg_t      dest;
        src_tag_t   src1;
        src_tag_t   src2;
        br_mask_t   br_mask;
    } dispatch_t;

    // operands are known ready once issued, so only the tags travel on
    typedef struct packed {
        logic       valid;
        fu_type_e   fu_type;
        logic [7:0] op;
        preg_t      dest;
        preg_t      src1;
        preg_t      src2;
        br_mask_t   br_mask;
    } rs_packet_t;

    typedef struct packed {
        logic  valid;
        preg_t tag;
    } cdb_t;

endpackage

// File: src/psel_gen.sv
module psel_gen #(
    parameter int WIDTH = 8,
    parameter int REQS  = 2
) (
    input  logic [WIDTH-1:0]            req,
    output logic [REQS-1:0][WIDTH-1:0]  gnt_bus
);

    logic [WIDTH-1:0] remaining;

    // each row takes the lowest request still left over
    always_comb begin
        remaining = req;
        for (int r = 0; r < REQS; r++) begin
            // isolate lowest set bit
            gnt_bus[r] = remaining & (~remaining + 1'b1);
            remaining  = remaining & ~gnt_bus[r];
        end
    end

endmodule

// File: src/rs.sv
module rs import ooo_pkg::*; #(
    parameter int DEPTH    = rs_depth,
    parameter int N        = n_way,
    parameter int NUM_ALU  = num_alu,
    parameter int NUM_MULT = num_mult,
    parameter int NUM_LD   = num_ld,
    parameter int NUM_ST   = num_st,
    parameter int NUM_BR   = num_br
) (
    input  logic                          clock,
    input  logic                          reset,
    input  dispatch_t  [N-1:0]            dispatch,
    input  cdb_t       [N-1:0]            cdb,
    input  br_mask_t                      br_id,
    input  br_task_e                      br_task,
    input  logic       [NUM_ALU-1:0]      alu_busy,
    input  logic       [NUM_MULT-1:0]     mult_busy,
    input  logic       [NUM_LD-1:0]       ld_busy,
    input  logic       [NUM_ST-1:0]       st_busy,
    input  logic       [NUM_BR-1:0]       br_busy,
    output rs_packet_t [NUM_ALU-1:0]      issued_alu,
    output rs_packet_t [NUM_MULT-1:0]     issued_mult,
    output rs_packet_t [NUM_LD-1:0]       issued_ld,
    output rs_packet_t [NUM_ST-1:0]       issued_st,
    output rs_packet_t [NUM_BR-1:0]       issued_br,
    output logic       [$clog2(N+1)-1:0]  open_entries
);

    localparam int CW = $clog2(DEPTH + 1);
    localparam int OW = $clog2(N + 1);

    dispatch_t [DEPTH-1:0] entries;
    dispatch_t [DEPTH-1:0] next_entries;
    logic [CW-1:0] num_entries;
    logic [CW-1:0] next_num_entries;

    logic [DEPTH-1:0] occupied;
    logic [DEPTH-1:0] ready;
    logic [DEPTH-1:0] squash_hit;
    logic [DEPTH-1:0] issue_hit;
    logic [DEPTH-1:0] free_next;
    logic [N-1:0][DEPTH-1:0] place_bus;
    logic [CW-1:0] num_issued;
    logic [CW-1:0] num_squashed;
    logic [CW-1:0] num_accepted;
    logic [CW-1:0] free_count;

    rs_select_if #(.DEPTH(DEPTH), .NUM_FU(NUM_ALU))  alu_sel  ();
    rs_select_if #(.DEPTH(DEPTH), .NUM_FU(NUM_MULT)) mult_sel ();
    rs_select_if #(.DEPTH(DEPTH), .NUM_FU(NUM_LD))   ld_sel   ();
    rs_select_if #(.DEPTH(DEPTH), .NUM_FU(NUM_ST))   st_sel   ();
    rs_select_if #(.DEPTH(DEPTH), .NUM_FU(NUM_BR))   br_sel   ();

    rs_issue_select #(.DEPTH(DEPTH), .NUM_FU(NUM_ALU))  alu_issue  (.sel(alu_sel.selector));
    rs_issue_select #(.DEPTH(DEPTH), .NUM_FU(NUM_MULT)) mult_issue (.sel(mult_sel.selector));
    rs_issue_select #(.DEPTH(DEPTH), .NUM_FU(NUM_LD))   ld_issue   (.sel(ld_sel.selector));
    rs_issue_select #(.DEPTH(DEPTH), .NUM_FU(NUM_ST))   st_issue   (.sel(st_sel.selector));
    rs_issue_select #(.DEPTH(DEPTH), .NUM_FU(NUM_BR))   br_issue   (.sel(br_sel.selector));

    // sets ready if any broadcast lane carries the tag
    function automatic src_tag_t wake(src_tag_t src, cdb_t [N-1:0] bus);
        src_tag_t res;
        res = src;
        for (int i = 0; i < N; i++) begin
            if (bus[i].valid && bus[i].tag == src.tag) begin
                res.ready = 1'b1;
            end
        end
        return res;
    endfunction

    function automatic rs_packet_t to_packet(dispatch_t d);
        rs_packet_t p;
        p.valid   = d.valid;
        p.fu_type = d.fu_type;
        p.op      = d.op;
        p.dest    = d.dest;
        p.src1    = d.src1.tag;
        p.src2    = d.src2.tag;
        p.br_mask = d.br_mask;
        return p;
    endfunction

    // a squashed entry is dropped before it can request a unit
    always_comb begin
        for (int j = 0; j < DEPTH; j++) begin
            occupied[j]   = entries[j].valid;
            squash_hit[j] = (br_task == squash) && entries[j].valid &&
                            (|(entries[j].br_mask & br_id));
            ready[j]      = entries[j].valid && entries[j].src1.ready &&
                            entries[j].src2.ready && !squash_hit[j];
        end
    end

    always_comb begin
        alu_sel.req  = '0;
        mult_sel.req = '0;
        ld_sel.req   = '0;
        st_sel.req   = '0;
        br_sel.req   = '0;
        for (int j = 0; j < DEPTH; j++) begin
            if (ready[j]) begin
                case (entries[j].fu_type)
                    fu_alu:  alu_sel.req[j]  = 1'b1;
                    fu_mult: mult_sel.req[j] = 1'b1;
                    fu_ld:   ld_sel.req[j]   = 1'b1;
                    fu_st:   st_sel.req[j]   = 1'b1;
                    fu_br:   br_sel.req[j]   = 1'b1;
                    default: ;
                endcase
            end
        end
    end

    assign alu_sel.fu_free  = ~alu_busy;
    assign mult_sel.fu_free = ~mult_busy;
    assign ld_sel.fu_free   = ~ld_busy;
    assign st_sel.fu_free   = ~st_busy;
    assign br_sel.fu_free   = ~br_busy;

    // every slot that leaves this cycle, over all classes
    always_comb begin
        issue_hit = '0;
        for (int u = 0; u < NUM_ALU; u++) begin
            issue_hit = issue_hit | alu_sel.grant[u];
        end
        for (int u = 0; u < NUM_MULT; u++) begin
            issue_hit = issue_hit | mult_sel.grant[u];
        end
        for (int u = 0; u < NUM_LD; u++) begin
            issue_hit = issue_hit | ld_sel.grant[u];
        end
        for (int u = 0; u < NUM_ST; u++) begin
            issue_hit = issue_hit | st_sel.grant[u];
        end
        for (int u = 0; u < NUM_BR; u++) begin
            issue_hit = issue_hit | br_sel.grant[u];
        end
    end

    assign num_issued = CW'(alu_sel.count) + CW'(mult_sel.count) + CW'(ld_sel.count) +
                        CW'(st_sel.count) + CW'(br_sel.count);

    // slots vacated this cycle can be refilled at the same edge
    assign free_next = ~occupied | issue_hit | squash_hit;

    psel_gen #(
        .WIDTH (DEPTH),
        .REQS  (N)
    ) place_sel (
        .req     (free_next),
        .gnt_bus (place_bus)
    );

    always_comb begin
        next_entries = entries;
        num_squashed = '0;
        for (int j = 0; j < DEPTH; j++) begin
            next_entries[j].src1 = wake(entries[j].src1, cdb);
            next_entries[j].src2 = wake(entries[j].src2, cdb);
            if (br_task == clear) begin
                next_entries[j].br_mask = entries[j].br_mask & ~br_id;
            end
            if (squash_hit[j]) begin
                num_squashed = num_squashed + 1'b1;
            end
            if (squash_hit[j] || issue_hit[j]) begin
                next_entries[j].valid = 1'b0;
            end
        end

        // n-th valid lane takes the n-th free slot
        num_accepted = '0;
        for (int i = 0; i < N; i++) begin
            if (dispatch[i].valid) begin
                for (int j = 0; j < DEPTH; j++) begin
                    if (place_bus[num_accepted][j]) begin
                        next_entries[j]      = dispatch[i];
                        // bypass from a same-cycle broadcast
                        next_entries[j].src1 = wake(dispatch[i].src1, cdb);
                        next_entries[j].src2 = wake(dispatch[i].src2, cdb);
                    end
                end
                num_accepted = num_accepted + 1'b1;
            end
        end

        next_num_entries = num_entries - num_issued - num_squashed + num_accepted;
    end

    assign free_count   = CW'(DEPTH) - num_entries;
    assign open_entries = (free_count > CW'(N)) ? OW'(N) : OW'(free_count);

    always_comb begin
        issued_alu  = '0;
        issued_mult = '0;
        issued_ld   = '0;
        issued_st   = '0;
        issued_br   = '0;
        for (int j = 0; j < DEPTH; j++) begin
            for (int u = 0; u < NUM_ALU; u++) begin
                if (alu_sel.grant[u][j]) begin
                    issued_alu[u] = to_packet(entries[j]);
                end
            end
            for (int u = 0; u < NUM_MULT; u++) begin
                if (mult_sel.grant[u][j]) begin
                    issued_mult[u] = to_packet(entries[j]);
                end
            end
            for (int u = 0; u < NUM_LD; u++) begin
                if (ld_sel.grant[u][j]) begin
                    issued_ld[u] = to_packet(entries[j]);
                end
            end
            for (int u = 0; u < NUM_ST; u++) begin
                if (st_sel.grant[u][j]) begin
                    issued_st[u] = to_packet(entries[j]);
                end
            end
            for (int u = 0; u < NUM_BR; u++) begin
                if (br_sel.grant[u][j]) begin
                    issued_br[u] = to_packet(entries[j]);
                end
            end
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            num_entries <= '0;
            for (int j = 0; j < DEPTH; j++) begin
                entries[j].valid <= 1'b0;
            end
        end else begin
            entries     <= next_entries;
            num_entries <= next_num_entries;
        end
    end

endmodule

// File: src/rs_issue_select.sv
module rs_issue_select #(
    parameter int DEPTH  = 8,
    parameter int NUM_FU = 1
) (
    rs_select_if.selector sel
);

    localparam int CW = $clog2(NUM_FU + 1);

    logic [NUM_FU-1:0][DEPTH-1:0] cand;
    logic [CW-1:0] slot;
    logic [CW-1:0] issued;

    // oldest-slot-first candidates, as many as there are units
    psel_gen #(
        .WIDTH (DEPTH),
        .REQS  (NUM_FU)
    ) cand_sel (
        .req     (sel.req),
        .gnt_bus (cand)
    );

    // candidate k goes to the k-th free unit, busy units get nothing
    always_comb begin
        slot   = '0;
        issued = '0;
        for (int u = 0; u < NUM_FU; u++) begin
            sel.grant[u] = '0;
            if (sel.fu_free[u]) begin
                sel.grant[u] = cand[slot];
                if (|cand[slot]) begin
                    issued = issued + 1'b1;
                end
                slot = slot + 1'b1;
            end
        end
        sel.count = issued;
    end

endmodule

// File: src/rs_select_if.sv
interface rs_select_if #(
    parameter int DEPTH  = 8,
    parameter int NUM_FU = 1
);

    // ready entries of this class
    logic [DEPTH-1:0] req;
    logic [NUM_FU-1:0] fu_free;

    // one row per unit, at most one bit set per row
    logic [NUM_FU-1:0][DEPTH-1:0] grant;
    logic [$clog2(NUM_FU+1)-1:0] count;

    modport station (
        output req,
        output fu_free,
        input  grant,
        input  count
    );

    modport selector (
        input  req,
        input  fu_free,
        output grant,
        output count
    );

endinterface

// File: src/rs_top.sv
module rs_top import ooo_pkg::*; #(
    parameter int DEPTH    = rs_depth,
    parameter int N        = n_way,
    parameter int NUM_ALU  = num_alu,
    parameter int NUM_MULT = num_mult,
    parameter int NUM_LD   = num_ld,
    parameter int NUM_ST   = num_st,
    parameter int NUM_BR   = num_br
) (
    input  logic                          clock,
    input  logic                          reset,

    // from the dispatch stage
    input  dispatch_t  [N-1:0]            dispatch,

    // writeback and branch resolution
    input  cdb_t       [N-1:0]            cdb,
    input  br_mask_t                      br_id,
    input  br_task_e                      br_task,

    // unit busy levels
    input  logic       [NUM_ALU-1:0]      alu_busy,
    input  logic       [NUM_MULT-1:0]     mult_busy,
    input  logic       [NUM_LD-1:0]       ld_busy,
    input  logic       [NUM_ST-1:0]       st_busy,
    input  logic       [NUM_BR-1:0]       br_busy,

    // one packet per unit
    output rs_packet_t [NUM_ALU-1:0]      issued_alu,
    output rs_packet_t [NUM_MULT-1:0]     issued_mult,
    output rs_packet_t [NUM_LD-1:0]       issued_ld,
    output rs_packet_t [NUM_ST-1:0]       issued_st,
    output rs_packet_t [NUM_BR-1:0]       issued_br,

    // dispatch limit for the next edge
    output logic       [$clog2(N+1)-1:0]  open_entries
);

    rs #(
        .DEPTH    (DEPTH),
        .N        (N),
        .NUM_ALU  (NUM_ALU),
        .NUM_MULT (NUM_MULT),
        .NUM_LD   (NUM_LD),
        .NUM_ST   (NUM_ST),
        .NUM_BR   (NUM_BR)
    ) station (
        .clock        (clock),
        .reset        (reset),
        .dispatch     (dispatch),
        .cdb          (cdb),
        .br_id        (br_id),
        .br_task      (br_task),
        .alu_busy     (alu_busy),
        .mult_busy    (mult_busy),
        .ld_busy      (ld_busy),
        .st_busy      (st_busy),
        .br_busy      (br_busy),
        .issued_alu   (issued_alu),
        .issued_mult  (issued_mult),
        .issued_ld    (issued_ld),
        .issued_st    (issued_st),
        .issued_br    (issued_br),
        .open_entries (open_entries)
    );

endmodule

// File: verif/rs_checker.sv
module rs_checker #(
    parameter int DEPTH = 8
) (
    input  logic                        clock,
    input  logic                        reset,
    input  logic [$clog2(DEPTH+1)-1:0]  num_entries,
    input  logic [$clog2(DEPTH+1)-1:0]  num_issued,
    input  logic [DEPTH-1:0]            occupied,
    input  logic [DEPTH-1:0]            issue_hit
);
    timeunit 1ns;
    timeprecision 100ps;

    int failures = 0;

    occupancy_bounded: assert property (@(posedge clock) disable iff (reset)
        num_entries <= DEPTH)
    else begin
        failures++;
        $error("occupancy count %0d above %0d entries", num_entries, DEPTH);
    end

    occupancy_matches: assert property (@(posedge clock) disable iff (reset)
        num_entries == $countones(occupied))
    else begin
        failures++;
        $error("occupancy count %0d but %0d valid entries", num_entries, $countones(occupied));
    end

    // an entry granted twice would leave fewer distinct slots than issues
    single_grant: assert property (@(posedge clock) disable iff (reset)
        $countones(issue_hit) == num_issued)
    else begin
        failures++;
        $error("%0d issues from %0d distinct entries", num_issued, $countones(issue_hit));
    end

endmodule

bind rs rs_checker #(.DEPTH(DEPTH)) count_checks (
    .clock       (clock),
    .reset       (reset),
    .num_entries (num_entries),
    .num_issued  (num_issued),
    .occupied    (occupied),
    .issue_hit   (issue_hit)
);

// File: verif/rs_monitor.sv
module rs_monitor import ooo_pkg::*; #(
    parameter int DEPTH = rs_depth,
    parameter int UNITS = num_alu + num_mult + num_ld + num_st + num_br
) (
    input  logic                           clock,
    input  logic                           reset,
    input  dispatch_t  [n_way-1:0]         dispatch,
    input  cdb_t       [n_way-1:0]         cdb,
    input  br_mask_t                       br_id,
    input  br_task_e                       br_task,
    input  logic       [UNITS-1:0]         busy,
    input  rs_packet_t [UNITS-1:0]         issued,
    input  logic       [$clog2(n_way+1)-1:0] open_entries,
    output int                             errors,
    output int                             checks,
    output int                             occupancy
);
    timeunit 1ns;
    timeprecision 100ps;

    localparam int IW = $clog2(DEPTH);
    localparam int OW = $clog2(n_way + 1);

    typedef dispatch_t [DEPTH-1:0] entry_arr_t;
    // per unit: valid bit on top, entry index below
    typedef logic [UNITS-1:0][IW:0] pick_t;

    entry_arr_t model = '0;

    initial begin
        errors    = 0;
        checks    = 0;
        occupancy = 0;
    end

    // units are numbered alu first, then mult, ld, st, br
    function automatic fu_type_e unit_class(int u);
        if (u < num_alu) return fu_alu;
        if (u < num_alu + num_mult) return fu_mult;
        if (u < num_alu + num_mult + num_ld) return fu_ld;
        if (u < num_alu + num_mult + num_ld + num_st) return fu_st;
        return fu_br;
    endfunction

    function automatic logic broadcast_hit(preg_t tag, cdb_t [n_way-1:0] bus);
        for (int i = 0; i < n_way; i++) begin
            if (bus[i].valid && bus[i].tag == tag) return 1'b1;
        end
        return 1'b0;
    endfunction

    // each free unit in order takes the lowest ready entry of its class left over
    function automatic pick_t pick_units(entry_arr_t ent, logic [UNITS-1:0] busy_now,
                                         logic [DEPTH-1:0] killed);
        pick_t res;
        logic [DEPTH-1:0] taken;
        logic found;
        res   = '0;
        taken = '0;
        for (int u = 0; u < UNITS; u++) begin
            found = 1'b0;
            for (int j = 0; j < DEPTH; j++) begin
                if (!busy_now[u] && !found && !taken[j] && ent[j].valid && !killed[j] &&
                    ent[j].src1.ready && ent[j].src2.ready && ent[j].fu_type == unit_class(u)) begin
                    found    = 1'b1;
                    taken[j] = 1'b1;
                    res[u]   = {1'b1, IW'(j)};
                end
            end
        end
        return res;
    endfunction

    function automatic entry_arr_t next_state(entry_arr_t cur, logic [DEPTH-1:0] gone,
            dispatch_t [n_way-1:0] lanes, cdb_t [n_way-1:0] bus, br_mask_t id, br_task_e bt);
        entry_arr_t nxt;
        int open_slots[$];
        int slot;
        nxt = cur;
        for (int j = 0; j < DEPTH; j++) begin
            nxt[j].src1.ready = cur[j].src1.ready | broadcast_hit(cur[j].src1.tag, bus);
            nxt[j].src2.ready = cur[j].src2.ready | broadcast_hit(cur[j].src2.tag, bus);
            if (bt == clear) nxt[j].br_mask = cur[j].br_mask & ~id;
            if (gone[j]) nxt[j].valid = 1'b0;
            if (!nxt[j].valid) open_slots.push_back(j);
        end
        for (int i = 0; i < n_way; i++) begin
            if (lanes[i].valid && open_slots.size() > 0) begin
                slot = open_slots.pop_front();
                nxt[slot] = lanes[i];
                nxt[slot].src1.ready = lanes[i].src1.ready | broadcast_hit(lanes[i].src1.tag, bus);
                nxt[slot].src2.ready = lanes[i].src2.ready | broadcast_hit(lanes[i].src2.tag, bus);
            end
        end
        return nxt;
    endfunction

    // inputs settle 2 ns after the rising edge, so the falling edge sees a stable cycle
    always @(negedge clock) begin : compare_cycle
        logic [DEPTH-1:0] killed;
        logic [DEPTH-1:0] gone;
        pick_t picks;
        rs_packet_t want;
        dispatch_t e;
        int held;
        int exp_open;
        if (reset) begin
            model     = '0;
            occupancy = 0;
        end else begin
            held = 0;
            for (int j = 0; j < DEPTH; j++) begin
                killed[j] = br_task == squash && model[j].valid && (model[j].br_mask & br_id) != 0;
                if (model[j].valid) held++;
            end
            exp_open = (DEPTH - held < n_way) ? DEPTH - held : n_way;
            checks++;
            if (open_entries !== OW'(exp_open)) begin
                errors++;
                $display("[ERROR] %0t open_entries expected %0d, got %0d",
                         $time, exp_open, open_entries);
            end
            picks = pick_units(model, busy, killed);
            gone  = killed;
            for (int u = 0; u < UNITS; u++) begin
                want = '0;
                if (picks[u][IW]) begin
                    e    = model[picks[u][IW-1:0]];
                    want = '{valid: 1'b1, fu_type: e.fu_type, op: e.op, dest: e.dest,
                             src1: e.src1.tag, src2: e.src2.tag, br_mask: e.br_mask};
                    gone[picks[u][IW-1:0]] = 1'b1;
                end
                checks++;
                if (issued[u] !== want) begin
                    errors++;
                    $display("[ERROR] %0t issue unit %0d expected %h, got %h",
                             $time, u, want, issued[u]);
                end
            end
            model     = next_state(model, gone, dispatch, cdb, br_id, br_task);
            occupancy = 0;
            for (int j = 0; j < DEPTH; j++) begin
                if (model[j].valid) occupancy++;
            end
        end
    end

endmodule

// File: verif/rs_tb.sv
module rs_tb import ooo_pkg::*; ();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int OW    = $clog2(n_way + 1);
    localparam int UNITS = num_alu + num_mult + num_ld + num_st + num_br;

    logic clock;
    logic reset;
    dispatch_t  [n_way-1:0]    dispatch;
    cdb_t       [n_way-1:0]    cdb;
    br_mask_t                  br_id;
    br_task_e                  br_task;
    logic       [num_alu-1:0]  alu_busy;
    logic       [num_mult-1:0] mult_busy;
    logic       [num_ld-1:0]   ld_busy;
    logic       [num_st-1:0]   st_busy;
    logic       [num_br-1:0]   br_busy;
    rs_packet_t [num_alu-1:0]  issued_alu;
    rs_packet_t [num_mult-1:0] issued_mult;
    rs_packet_t [num_ld-1:0]   issued_ld;
    rs_packet_t [num_st-1:0]   issued_st;
    rs_packet_t [num_br-1:0]   issued_br;
    logic       [OW-1:0]       open_entries;

    logic [31:0] lfsr = 32'h454a;
    int errors;
    int checks;
    int occupancy;
    int waited;
    bit timed_out;

    rs_top UUT (.*);

    rs_monitor monitor (
        .clock, .reset, .dispatch, .cdb, .br_id, .br_task, .open_entries,
        .busy      ({br_busy, st_busy, ld_busy, mult_busy, alu_busy}),
        .issued    ({issued_br, issued_st, issued_ld, issued_mult, issued_alu}),
        .errors    (errors),
        .checks    (checks),
        .occupancy (occupancy)
    );

    always #10 clock = ~clock;

    // taps 32, 22, 2, 1
    function automatic logic [31:0] rand_bits(int n);
        logic [31:0] val;
        val = '0;
        for (int b = 0; b < n; b++) begin
            lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
            val  = {val[30:0], lfsr[0]};
        end
        return val;
    endfunction

    function automatic dispatch_t make_instr(bit all_ready);
        dispatch_t d;
        d.valid      = 1'b0;
        d.fu_type    = fu_type_e'(3'(rand_bits(3) % 5));
        d.op         = 8'(rand_bits(8));
        d.dest       = preg_t'(rand_bits(6));
        // narrow tag range so broadcasts hit often
        d.src1.tag   = preg_t'(rand_bits(4));
        d.src1.ready = all_ready | (rand_bits(2) != 0);
        d.src2.tag   = preg_t'(rand_bits(4));
        d.src2.ready = all_ready | (rand_bits(2) != 0);
        d.br_mask    = br_mask_t'(rand_bits(4) & rand_bits(4));
        return d;
    endfunction

    task automatic random_inputs(input bit dispatching, input bit all_ready,
                                 input bit branches, input logic [UNITS-1:0] busy_force);
        int allowed;
        logic take;
        logic [3:0] pick;
        dispatch_t d;
        allowed = int'(open_entries);
        for (int i = 0; i < n_way; i++) begin
            d       = make_instr(all_ready);
            take    = (rand_bits(2) != 0);
            d.valid = dispatching && take && (i < allowed);
            dispatch[i]  = d;
            cdb[i].valid = 1'(rand_bits(1));
            cdb[i].tag   = preg_t'(rand_bits(4));
        end
        {br_busy, st_busy, ld_busy, mult_busy, alu_busy} =
            UNITS'(rand_bits(UNITS) & rand_bits(UNITS)) | busy_force;
        br_id   = br_mask_t'(1) << rand_bits(2);
        pick    = 4'(rand_bits(4));
        br_task = no_task;
        if (branches && pick == 4'd0) begin
            br_task = squash;
        end else if (branches && pick == 4'd1) begin
            br_task = clear;
        end
    endtask

    // no dispatch, units free, broadcast every tag in turn
    task automatic drain_station(output bit late);
        waited = 0;
        while ((occupancy != 0 || open_entries != OW'(n_way)) && waited < 300) begin
            @(posedge clock);
            #2;
            dispatch = '0;
            br_task  = no_task;
            {br_busy, st_busy, ld_busy, mult_busy, alu_busy} = '0;
            for (int i = 0; i < n_way; i++) begin
                cdb[i] = '{valid: 1'b1, tag: preg_t'((waited * n_way + i) % 16)};
            end
            waited++;
        end
        late = (occupancy != 0 || open_entries != OW'(n_way));
        if (late) begin
            $display("station did not drain within 300 cycles");
        end
    endtask

    initial begin
        clock    = 1'b0;
        reset    = 1'b1;
        dispatch = '0;
        cdb      = '0;
        br_id    = '0;
        br_task  = no_task;
        {br_busy, st_busy, ld_busy, mult_busy, alu_busy} = '0;
        timed_out = 1'b0;
        repeat (8) @(posedge clock);
        #2;
        reset = 1'b0;

        repeat (40) begin
            @(posedge clock);
            #2;
            random_inputs(1'b1, 1'b1, 1'b0, '0);
        end

        // every unit busy, so nothing leaves until the drain
        waited = 0;
        while (open_entries != 0 && waited < 100) begin
            @(posedge clock);
            #2;
            random_inputs(1'b1, 1'b1, 1'b0, '1);
            waited++;
        end
        if (open_entries != 0) begin
            timed_out = 1'b1;
            $display("station did not fill with all units busy");
        end
        if (!timed_out) begin
            drain_station(timed_out);
        end

        if (!timed_out) begin
            repeat (3000) begin
                @(posedge clock);
                #2;
                random_inputs(1'b1, 1'b0, 1'b1, '0);
            end
            drain_station(timed_out);
        end

        @(posedge clock);
        #2;
        $display("checks %0d, errors %0d, assertion failures %0d",
                 checks, errors, UUT.station.count_checks.failures);
        if (timed_out || errors != 0 || UUT.station.count_checks.failures != 0) begin
            $display("TEST FAIL");
        end else begin
            $display("TEST PASS");
        end
        $finish;
    end

endmodule
